//--- design/irq_csr_pkg.sv
`default_nettype none

package irq_csr_pkg;

  //////////////////////////////////////////////////////////////////////
  // CSR addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [11:0] CSR_ADDR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_ADDR_MIE     = 12'h304;
  localparam logic [11:0] CSR_ADDR_MIP     = 12'h344;

  // Global machine interrupt enable inside mstatus
  localparam int unsigned MSTATUS_MIE_BIT = 3;

  // Implemented lines: MSI 3, MTI 7, MEI 11, platform 16 to 31
  localparam logic [31:0] IRQ_IMPL_MASK = 32'hFFFF_0888;

  //////////////////////////////////////////////////////////////////////
  // mie / mip word layout
  //////////////////////////////////////////////////////////////////////

  // Field order is MSB first
  typedef struct packed {
    logic [15:0] platform;     // Lines 31..16
    logic [3:0]  reserved_hi;  // Lines 15..12
    logic        meip;         // Line 11
    logic [2:0]  reserved_10;  // Lines 10..8
    logic        mtip;         // Line 7
    logic [2:0]  reserved_6;   // Lines 6..4
    logic        msip;         // Line 3
    logic [2:0]  reserved_2;   // Lines 2..0
  } csr_irq_fields_t;

  // Raw view for the CSR port, field view for priority decode
  typedef union packed {
    logic [31:0]     raw;
    csr_irq_fields_t fields;
  } csr_irq_word_u;

endpackage

`default_nettype wire

//--- design/irq_id_pkg.sv
`default_nettype none

package irq_id_pkg;

  //////////////////////////////////////////////////////////////////////
  // Line count and id encoding
  //////////////////////////////////////////////////////////////////////

  // Width of an interrupt id
  localparam int unsigned IRQ_ID_W = 5;

  // One line per mip bit
  localparam int unsigned NUM_IRQ = 32;

  // Standard machine-level ids
  localparam logic [IRQ_ID_W-1:0] IRQ_ID_MSI = 5'd3;
  localparam logic [IRQ_ID_W-1:0] IRQ_ID_MTI = 5'd7;
  localparam logic [IRQ_ID_W-1:0] IRQ_ID_MEI = 5'd11;

  //////////////////////////////////////////////////////////////////////
  // Priority order
  //////////////////////////////////////////////////////////////////////

  // Highest first:
  //   platform 31 down to 16
  //   then MEI, MSI, MTI
  // Platform lines start here
  localparam int unsigned IRQ_ID_PLAT_BASE = 16;

  // Number of platform lines
  localparam int unsigned NUM_PLAT_IRQ = 16;

endpackage

`default_nettype wire

//--- design/irq_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module irq_csr_unit (
  input  logic                           clk_i,
  input  logic                           rst_i,

  // CSR port, single-cycle write strobe
  input  logic                           csr_we_i,
  input  logic [11:0]                    csr_addr_i,
  input  logic [31:0]                    csr_wdata_i,
  output logic [31:0]                    csr_rdata_o,

  // Pending word from the line cells
  input  logic [irq_id_pkg::NUM_IRQ-1:0] mip_i,

  // Enables toward the line cells and arbiter
  output logic [irq_id_pkg::NUM_IRQ-1:0] mie_o,
  output logic                           global_en_o
);

  // Only MIE is writable in mstatus
  localparam logic [31:0] MSTATUS_WMASK = 32'd1 << irq_csr_pkg::MSTATUS_MIE_BIT;

  // Register state
  irq_csr_pkg::csr_irq_word_u mie_q;
  irq_csr_pkg::csr_irq_word_u mstatus_q;

  // Next-state values
  irq_csr_pkg::csr_irq_word_u mie_d;
  irq_csr_pkg::csr_irq_word_u mstatus_d;

  //////////////////////////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mie_d     = mie_q;
    mstatus_d = mstatus_q;
    if (csr_we_i) begin
      case (csr_addr_i)
        irq_csr_pkg::CSR_ADDR_MIE: begin
          // Unimplemented lines stay zero
          mie_d.raw = csr_wdata_i & irq_csr_pkg::IRQ_IMPL_MASK;
        end
        irq_csr_pkg::CSR_ADDR_MSTATUS: begin
          mstatus_d.raw = csr_wdata_i & MSTATUS_WMASK;
        end
        // mip is driven by the lines, writes dropped
        default: begin
          mie_d     = mie_q;
          mstatus_d = mstatus_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mie_q.raw     <= '0;
      mstatus_q.raw <= '0;
    end else begin
      mie_q     <= mie_d;
      mstatus_q <= mstatus_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////

  // Combinational, same cycle as the address
  always_comb begin
    case (csr_addr_i)
      irq_csr_pkg::CSR_ADDR_MSTATUS: csr_rdata_o = mstatus_q.raw;
      irq_csr_pkg::CSR_ADDR_MIE:     csr_rdata_o = mie_q.raw;
      irq_csr_pkg::CSR_ADDR_MIP:     csr_rdata_o = mip_i;
      default:                       csr_rdata_o = '0;
    endcase
  end

  // Outputs
  assign mie_o       = mie_q.raw;
  assign global_en_o = mstatus_q.raw[irq_csr_pkg::MSTATUS_MIE_BIT];

  // No enable may reach a line that has no cell behind it
  a_mie_impl_only : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (mie_q.raw & ~irq_csr_pkg::IRQ_IMPL_MASK) == '0
  ) else $error("irq_csr_unit: mie holds an unimplemented bit");

endmodule

`default_nettype wire

//--- design/irq_line.sv
`timescale 1ns/1ps
`default_nettype none

module irq_line #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic clk_i,
  input  logic rst_i,

  // Raw line, asynchronous to clk_i
  input  logic irq_i,

  // This line's mie bit
  input  logic enable_i,

  // Synchronized level, reported in mip
  output logic pending_o,

  // Pending and enabled, toward the arbiter
  output logic active_o
);

  // Synchronizer chain, bit 0 samples the pin
  logic [SYNC_STAGES-1:0] sync_q;

  // Two or three stages supported
  if ((SYNC_STAGES < 2) || (SYNC_STAGES > 3)) begin : g_bad_stages
    $error("irq_line: SYNC_STAGES must be 2 or 3");
  end

  //////////////////////////////////////////////////////////////////////
  // Synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q <= '0;
    end else begin
      // Shift toward the MSB
      sync_q <= {sync_q[SYNC_STAGES-2:0], irq_i};
    end
  end

  // Last stage doubles as the pending flag
  assign pending_o = sync_q[SYNC_STAGES-1];

  // Level-sensitive, no latching of the request
  assign active_o = pending_o & enable_i;

  // A rising pending flag was on the pin SYNC_STAGES cycles before
  a_pending_latency : assert property (
    @(posedge clk_i) disable iff (rst_i)
    $rose(pending_o) |-> $past(irq_i, SYNC_STAGES)
  ) else $error("irq_line: pending rose without the pin SYNC_STAGES cycles earlier");

endmodule

`default_nettype wire

//--- design/irq_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter (
  input  logic                            clk_i,
  input  logic                            rst_i,

  // From the line cells and the CSR unit
  input  logic [irq_id_pkg::NUM_IRQ-1:0]  active_i,
  input  logic [irq_id_pkg::NUM_IRQ-1:0]  mie_i,
  input  logic                            global_en_i,

  // Request toward the core, valid/ready style
  input  logic                            irq_ack_i,
  output logic                            irq_req_o,
  output logic [irq_id_pkg::IRQ_ID_W-1:0] irq_id_o,
  output logic                            irq_wu_o
);

  localparam int unsigned ID_W = irq_id_pkg::IRQ_ID_W;

  // Active vector, decoded through the field view
  irq_csr_pkg::csr_irq_word_u act;

  logic            win_valid;
  logic [ID_W-1:0] win_id;
  logic            held;
  logic            req_q;
  logic [ID_W-1:0] id_q;
  logic            wu_q;

  //////////////////////////////////////////////////////////////////////
  // Priority select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Only enabled lines compete
    act.raw = active_i & mie_i;
    win_id  = '0;
    // Lowest first, later hits override
    if (act.fields.mtip) begin
      win_id = irq_id_pkg::IRQ_ID_MTI;
    end
    if (act.fields.msip) begin
      win_id = irq_id_pkg::IRQ_ID_MSI;
    end
    if (act.fields.meip) begin
      win_id = irq_id_pkg::IRQ_ID_MEI;
    end
    // Platform lines, highest index wins
    for (int i = 0; i < irq_id_pkg::NUM_PLAT_IRQ; i++) begin
      if (act.fields.platform[i]) begin
        win_id = ID_W'(irq_id_pkg::IRQ_ID_PLAT_BASE + i);
      end
    end
  end

  assign win_valid = |act.raw;

  // Offer outstanding and not taken this cycle
  assign held = req_q & ~irq_ack_i;

  //////////////////////////////////////////////////////////////////////
  // Request register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q <= 1'b0;
      id_q  <= '0;
      wu_q  <= 1'b0;
    end else begin
      // Wake-up ignores mstatus.MIE
      wu_q <= win_valid;
      if (held) begin
        // Back-pressure: keep id, drop if source went away
        req_q <= global_en_i & act.raw[id_q];
      end else if (global_en_i) begin
        req_q <= win_valid;
        id_q  <= win_id;
      end else begin
        req_q <= 1'b0;
      end
    end
  end

  assign irq_req_o = req_q;
  assign irq_id_o  = id_q;
  assign irq_wu_o  = wu_q;

  // Payload frozen until the core takes it
  a_id_stable : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (irq_req_o && !irq_ack_i) |=> $stable(irq_id_o)
  ) else $error("irq_arbiter: id changed under back-pressure");

  // Global disable kills the request next cycle
  a_req_gated : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !global_en_i |=> !irq_req_o
  ) else $error("irq_arbiter: request while globally disabled");

endmodule

`default_nettype wire

//--- design/irq_controller_top.sv
`timescale 1ns/1ps
`default_nettype none

module irq_controller_top #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_i,

  // External interrupt lines
  input  logic [irq_id_pkg::NUM_IRQ-1:0]  irq_i,

  // CSR port
  input  logic                            csr_we_i,
  input  logic [11:0]                     csr_addr_i,
  input  logic [31:0]                     csr_wdata_i,
  output logic [31:0]                     csr_rdata_o,

  // Request toward the core
  input  logic                            irq_ack_i,
  output logic                            irq_req_o,
  output logic [irq_id_pkg::IRQ_ID_W-1:0] irq_id_o,
  output logic                            irq_wu_o
);

  // CSR unit to lines and arbiter
  logic [irq_id_pkg::NUM_IRQ-1:0] mie;
  logic                           global_en;

  // Lines back to CSR unit and arbiter
  logic [irq_id_pkg::NUM_IRQ-1:0] mip;
  logic [irq_id_pkg::NUM_IRQ-1:0] active;

  //////////////////////////////////////////////////////////////////////
  // CSR unit
  //////////////////////////////////////////////////////////////////////

  irq_csr_unit u_csr (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .csr_we_i    ( csr_we_i    ),
    .csr_addr_i  ( csr_addr_i  ),
    .csr_wdata_i ( csr_wdata_i ),
    .csr_rdata_o ( csr_rdata_o ),
    .mip_i       ( mip         ),
    .mie_o       ( mie         ),
    .global_en_o ( global_en   )
  );

  //////////////////////////////////////////////////////////////////////
  // Line cells
  //////////////////////////////////////////////////////////////////////

  // One cell per implemented index
  for (genvar i = 0; i < irq_id_pkg::NUM_IRQ; i++) begin : g_line
    if (irq_csr_pkg::IRQ_IMPL_MASK[i]) begin : g_impl
      irq_line #(
        .SYNC_STAGES ( SYNC_STAGES )
      ) u_line (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .irq_i     ( irq_i[i]  ),
        .enable_i  ( mie[i]    ),
        .pending_o ( mip[i]    ),
        .active_o  ( active[i] )
      );
    end else begin : g_unimpl
      // Reserved index, reads as zero
      assign mip[i]    = 1'b0;
      assign active[i] = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Arbiter
  //////////////////////////////////////////////////////////////////////

  irq_arbiter u_arb (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .active_i    ( active    ),
    .mie_i       ( mie       ),
    .global_en_i ( global_en ),
    .irq_ack_i   ( irq_ack_i ),
    .irq_req_o   ( irq_req_o ),
    .irq_id_o    ( irq_id_o  ),
    .irq_wu_o    ( irq_wu_o  )
  );

endmodule

`default_nettype wire

//--- verification/irq_checker.sv
`timescale 1ns/1ps
`default_nettype none

module irq_checker #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_i,

  // DUT inputs as driven by the testbench
  input  logic [irq_id_pkg::NUM_IRQ-1:0]  irq_i,
  input  logic                            csr_we_i,
  input  logic [11:0]                     csr_addr_i,
  input  logic [31:0]                     csr_wdata_i,
  input  logic                            irq_ack_i,

  // DUT outputs
  input  logic [31:0]                     csr_rdata_i,
  input  logic                            irq_req_i,
  input  logic [irq_id_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic                            irq_wu_i,

  // Check strobes from the testbench
  input  logic                            check_out_i,
  input  logic                            check_rd_i,
  input  logic                            hold_i,
  input  logic [95:0]                     test_name_i,

  output int unsigned                     err_cnt_o,
  output int unsigned                     chk_cnt_o
);

  localparam int unsigned ID_W = irq_id_pkg::IRQ_ID_W;
  localparam logic [31:0] MASK = irq_csr_pkg::IRQ_IMPL_MASK;

  // Expected CSR state, built from the observed writes
  logic [31:0]     mie_m;
  logic            en_m;
  logic [31:0]     irq_q;
  int unsigned     settle_cnt;

  // Last expected request, for back-pressure
  logic            prev_req;
  logic [ID_W-1:0] prev_id;
  logic            first_chk;
  logic [31:0]     act_m;
  logic            exp_req;
  logic            exp_wu;
  logic [ID_W-1:0] exp_id;
  logic [31:0]     exp_rd;
  int unsigned     errs = 0;
  int unsigned     checks = 0;

  assign err_cnt_o = errs;
  assign chk_cnt_o = checks;

  // Platform 31..16, then MEI, MSI, MTI
  function automatic logic [ID_W-1:0] top_line(input logic [31:0] act);
    logic [ID_W-1:0] id;
    logic            found;
    id    = '0;
    found = 1'b0;
    for (int i = 31; i >= 16; i--) begin
      if (!found && act[i]) begin
        id    = ID_W'(i);
        found = 1'b1;
      end
    end
    if (!found && act[irq_id_pkg::IRQ_ID_MEI]) begin
      id    = irq_id_pkg::IRQ_ID_MEI;
      found = 1'b1;
    end
    if (!found && act[irq_id_pkg::IRQ_ID_MSI]) begin
      id    = irq_id_pkg::IRQ_ID_MSI;
      found = 1'b1;
    end
    if (!found && act[irq_id_pkg::IRQ_ID_MTI]) begin
      id = irq_id_pkg::IRQ_ID_MTI;
    end
    return id;
  endfunction

  task automatic report_value(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    errs++;
    $display("FAIL %0s %0s: expected %h, actual %h", test_name_i, what, exp_v, act_v);
  endtask

  //////////////////////////////////////////////////////////////////////
  // CSR model and settle tracking
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_i) begin
      mie_m      <= '0;
      en_m       <= 1'b0;
      irq_q      <= '0;
      settle_cnt <= SYNC_STAGES;
    end else begin
      irq_q <= irq_i;
      if (settle_cnt < SYNC_STAGES) begin
        settle_cnt <= settle_cnt + 1;
      end
      // Any input change restarts the settle count
      if (irq_i != irq_q) begin
        settle_cnt <= 0;
      end
      if (csr_we_i && (csr_addr_i == irq_csr_pkg::CSR_ADDR_MIE)) begin
        mie_m      <= csr_wdata_i & MASK;
        settle_cnt <= 0;
      end
      if (csr_we_i && (csr_addr_i == irq_csr_pkg::CSR_ADDR_MSTATUS)) begin
        en_m       <= csr_wdata_i[irq_csr_pkg::MSTATUS_MIE_BIT];
        settle_cnt <= 0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare on the falling edge, away from the DUT updates
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_i) begin
      prev_req  = 1'b0;
      prev_id   = '0;
      first_chk = 1'b1;
    end
    if (!rst_i && check_out_i) begin
      act_m  = irq_i & MASK & mie_m;
      exp_wu = |act_m;
      // Held offer keeps its id while its line stays up
      if (hold_i && !irq_ack_i && prev_req && en_m && act_m[prev_id]) begin
        exp_req = 1'b1;
        exp_id  = prev_id;
      end else begin
        exp_req = en_m & exp_wu;
        exp_id  = top_line(act_m);
      end
      checks++;
      if (settle_cnt < SYNC_STAGES) begin
        errs++;
        $display("Output check in %0s came before the inputs had settled", test_name_i);
      end
      if (irq_req_i !== exp_req) begin
        report_value("irq_req", exp_req, irq_req_i);
      end
      // Id only means something while a request is up, or right after reset
      if ((exp_req || first_chk) && (irq_id_i !== exp_id)) begin
        report_value("irq_id", exp_id, irq_id_i);
      end
      if (irq_wu_i !== exp_wu) begin
        report_value("irq_wu", exp_wu, irq_wu_i);
      end
      prev_req  = exp_req;
      prev_id   = exp_id;
      first_chk = 1'b0;
    end
    if (!rst_i && check_rd_i) begin
      case (csr_addr_i)
        irq_csr_pkg::CSR_ADDR_MIE:     exp_rd = mie_m;
        irq_csr_pkg::CSR_ADDR_MSTATUS: exp_rd = 32'(en_m) << irq_csr_pkg::MSTATUS_MIE_BIT;
        irq_csr_pkg::CSR_ADDR_MIP:     exp_rd = irq_i & MASK;
        default:                       exp_rd = '0;
      endcase
      checks++;
      if (csr_rdata_i !== exp_rd) begin
        report_value("csr_rdata", exp_rd, csr_rdata_i);
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/irq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module irq_tb;

  localparam int unsigned SYNC_STAGES = 2;
  localparam int unsigned NUM_ROWS    = 16;
  localparam int unsigned NUM_RAND    = 4;
  localparam int unsigned MAX_CYCLES  = NUM_ROWS * (SYNC_STAGES + 8) + 50;
  localparam int unsigned DRIVE_DLY   = 10;
  localparam logic [31:0] LCG_SEED    = 32'h4b53_8e2b;

  // DUT ports
  logic                            clk_i;
  logic                            rst_i;
  logic [irq_id_pkg::NUM_IRQ-1:0]  irq_i;
  logic                            csr_we_i;
  logic [11:0]                     csr_addr_i;
  logic [31:0]                     csr_wdata_i;
  logic [31:0]                     csr_rdata_o;
  logic                            irq_ack_i;
  logic                            irq_req_o;
  logic [irq_id_pkg::IRQ_ID_W-1:0] irq_id_o;
  logic                            irq_wu_o;

  // Checker strobes
  logic                            check_out;
  logic                            check_rd;
  logic                            hold_chk;
  logic [95:0]                     test_name;
  int unsigned                     err_cnt;
  int unsigned                     chk_cnt;
  int unsigned                     cycle_cnt = 0;

  // Stimulus table
  logic [95:0] row_name [0:NUM_ROWS-1];
  logic [31:0] row_irq  [0:NUM_ROWS-1];
  logic [31:0] row_mie  [0:NUM_ROWS-1];
  logic [31:0] row_mst  [0:NUM_ROWS-1];
  logic        row_hold [0:NUM_ROWS-1];
  logic [31:0] lcg_state;

  irq_controller_top #(
    .SYNC_STAGES ( SYNC_STAGES )
  ) u_dut (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .irq_i       ( irq_i       ),
    .csr_we_i    ( csr_we_i    ),
    .csr_addr_i  ( csr_addr_i  ),
    .csr_wdata_i ( csr_wdata_i ),
    .csr_rdata_o ( csr_rdata_o ),
    .irq_ack_i   ( irq_ack_i   ),
    .irq_req_o   ( irq_req_o   ),
    .irq_id_o    ( irq_id_o    ),
    .irq_wu_o    ( irq_wu_o    )
  );

  irq_checker #(
    .SYNC_STAGES ( SYNC_STAGES )
  ) u_chk (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .irq_i       ( irq_i       ),
    .csr_we_i    ( csr_we_i    ),
    .csr_addr_i  ( csr_addr_i  ),
    .csr_wdata_i ( csr_wdata_i ),
    .irq_ack_i   ( irq_ack_i   ),
    .csr_rdata_i ( csr_rdata_o ),
    .irq_req_i   ( irq_req_o   ),
    .irq_id_i    ( irq_id_o    ),
    .irq_wu_i    ( irq_wu_o    ),
    .check_out_i ( check_out   ),
    .check_rd_i  ( check_rd    ),
    .hold_i      ( hold_chk    ),
    .test_name_i ( test_name   ),
    .err_cnt_o   ( err_cnt     ),
    .chk_cnt_o   ( chk_cnt     )
  );

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Driving tasks, all start and end just after a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) next_cycle();
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
    csr_we_i    = 1'b1;
    csr_addr_i  = addr;
    csr_wdata_i = data;
    next_cycle();
    csr_we_i = 1'b0;
  endtask

  task automatic read_check(input logic [95:0] name, input logic [11:0] addr);
    test_name  = name;
    csr_addr_i = addr;
    check_rd   = 1'b1;
    next_cycle();
    check_rd = 1'b0;
  endtask

  task automatic output_check(input logic [95:0] name, input logic hold);
    test_name = name;
    hold_chk  = hold;
    check_out = 1'b1;
    next_cycle();
    check_out = 1'b0;
  endtask

  // Outputs plus the mip read in one cycle
  task automatic check_all(input logic [95:0] name, input logic hold);
    test_name  = name;
    hold_chk   = hold;
    csr_addr_i = irq_csr_pkg::CSR_ADDR_MIP;
    check_out  = 1'b1;
    check_rd   = 1'b1;
    next_cycle();
    check_out = 1'b0;
    check_rd  = 1'b0;
  endtask

  task automatic set_row(input int unsigned r, input logic [95:0] name, input logic [31:0] irq,
                         input logic [31:0] mie, input logic [31:0] mst, input logic hold);
    row_name[r] = name;
    row_irq[r]  = irq;
    row_mie[r]  = mie;
    row_mst[r]  = mst;
    row_hold[r] = hold;
  endtask

  // Name, irq_i, mie, mstatus, hold ack low
  task automatic load_table();
    set_row(0,  "msi_only", 32'h0000_0008, 32'hFFFF_FFFF, 32'h8, 1'b0);
    set_row(1,  "mti_only", 32'h0000_0080, 32'hFFFF_FFFF, 32'h8, 1'b0);
    set_row(2,  "msi_mti",  32'h0000_0088, 32'hFFFF_FFFF, 32'h8, 1'b0);
    set_row(3,  "mei_msi",  32'h0000_0888, 32'hFFFF_FFFF, 32'h8, 1'b0);
    set_row(4,  "plat_lo",  32'h0001_0888, 32'hFFFF_FFFF, 32'h8, 1'b0);
    set_row(5,  "plat_hi",  32'h8001_0000, 32'hFFFF_FFFF, 32'h8, 1'b0);
    set_row(6,  "unimpl",   32'h0000_7777, 32'hFFFF_FFFF, 32'h8, 1'b0);
    set_row(7,  "mie_mask", 32'hFFFF_FFFF, 32'h0000_0080, 32'h8, 1'b0);
    set_row(8,  "gate_off", 32'h0000_0888, 32'hFFFF_FFFF, 32'h0, 1'b0);
    set_row(9,  "mie_off",  32'h0000_0888, 32'h0000_0000, 32'h8, 1'b0);
    set_row(10, "bp_base",  32'h0000_0080, 32'hFFFF_FFFF, 32'h8, 1'b0);
    // Same CSRs as the row before, line 17 joins under back-pressure
    set_row(11, "bp_hold",  32'h0002_0080, 32'hFFFF_FFFF, 32'h8, 1'b1);
    for (int unsigned r = NUM_ROWS - NUM_RAND; r < NUM_ROWS; r++) begin
      lcg_state = lcg_next(lcg_state);
      row_irq[r] = lcg_state;
      lcg_state = lcg_next(lcg_state);
      row_mie[r]  = lcg_state;
      row_mst[r]  = 32'h8;
      row_hold[r] = 1'b0;
      row_name[r] = {"rand_", 8'("0" + (r - (NUM_ROWS - NUM_RAND)))};
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_i       = 1'b1;
    irq_i       = '0;
    csr_we_i    = 1'b0;
    csr_addr_i  = '0;
    csr_wdata_i = '0;
    irq_ack_i   = 1'b0;
    check_out   = 1'b0;
    check_rd    = 1'b0;
    hold_chk    = 1'b0;
    test_name   = '0;
    lcg_state   = LCG_SEED;
    load_table();

    repeat (4) @(posedge clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;

    // Reset values
    output_check("reset", 1'b0);
    read_check("rst_mie", irq_csr_pkg::CSR_ADDR_MIE);
    read_check("rst_mst", irq_csr_pkg::CSR_ADDR_MSTATUS);
    read_check("rst_mip", irq_csr_pkg::CSR_ADDR_MIP);

    // Write masks
    write_csr(irq_csr_pkg::CSR_ADDR_MIE, 32'hFFFF_FFFF);
    read_check("mie_ones", irq_csr_pkg::CSR_ADDR_MIE);
    write_csr(irq_csr_pkg::CSR_ADDR_MSTATUS, 32'hFFFF_FFFF);
    read_check("mst_ones", irq_csr_pkg::CSR_ADDR_MSTATUS);
    // Pattern differs from what mie and mstatus hold now
    write_csr(irq_csr_pkg::CSR_ADDR_MIP, 32'h0001_0080);
    read_check("mip_write", irq_csr_pkg::CSR_ADDR_MIP);
    read_check("mie_kept", irq_csr_pkg::CSR_ADDR_MIE);
    read_check("mst_kept", irq_csr_pkg::CSR_ADDR_MSTATUS);

    // Table rows
    for (int unsigned r = 0; r < NUM_ROWS; r++) begin
      irq_ack_i = !row_hold[r];
      write_csr(irq_csr_pkg::CSR_ADDR_MIE, row_mie[r]);
      write_csr(irq_csr_pkg::CSR_ADDR_MSTATUS, row_mst[r]);
      irq_i = row_irq[r];
      wait_cycles(SYNC_STAGES + 3);
      check_all(row_name[r], row_hold[r]);
      if (row_hold[r]) begin
        // One ack, new winner within two cycles
        irq_ack_i = 1'b1;
        next_cycle();
        irq_ack_i = 1'b0;
        wait_cycles(1);
        output_check(row_name[r], 1'b0);
      end
    end

    wait_cycles(2);
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- irq_controller.f
design/irq_csr_pkg.sv
design/irq_id_pkg.sv
design/irq_csr_unit.sv
design/irq_line.sv
design/irq_arbiter.sv
design/irq_controller_top.sv
verification/irq_checker.sv
verification/irq_tb.sv
